// ==== rtl/vec_alu_cfg.svh ====
/* Size and APB register map macros for the vector ALU engine */
`ifndef VEC_ALU_CFG_SVH
`define VEC_ALU_CFG_SVH

// Datapath sizes
`define VEC_ELEM_W      32
`define VEC_VLMAX       8
`define VEC_NUM_REGS    4
`define VEC_APB_ADDR_W  8

// Field widths that follow from the sizes
`define VEC_IDX_W       3
`define VEC_REG_W       2
`define VEC_VL_W        4
`define VEC_IMM_W       12

// Control registers above the element window
`define VEC_ADDR_CMD    8'h80
`define VEC_ADDR_VL     8'h84
`define VEC_ADDR_STATUS 8'h88

`endif

// ==== rtl/vec_alu_pkg.sv ====
/* Element type, ALU function codes and the two views of the command word */
`include "vec_alu_cfg.svh"

package vec_alu_pkg;

  typedef logic [`VEC_ELEM_W-1:0] elem_t;

  // Codes 10 to 15 are reserved
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_fn_t;

  // mode, fn, vd and vs1 sit at the top of both views
  localparam int CMD_HEAD_W = 1 + 4 + 2 * `VEC_REG_W;

  typedef struct packed {
    logic                                         mode;
    alu_fn_t                                      fn;
    logic [`VEC_REG_W-1:0]                        vd;
    logic [`VEC_REG_W-1:0]                        vs1;
    logic [`VEC_ELEM_W-CMD_HEAD_W-`VEC_REG_W-1:0] pad;
    logic [`VEC_REG_W-1:0]                        vs2;
  } cmd_vv_t;

  typedef struct packed {
    logic                                         mode;
    alu_fn_t                                      fn;
    logic [`VEC_REG_W-1:0]                        vd;
    logic [`VEC_REG_W-1:0]                        vs1;
    logic [`VEC_ELEM_W-CMD_HEAD_W-`VEC_IMM_W-1:0] pad;
    logic signed [`VEC_IMM_W-1:0]                 imm;
  } cmd_vi_t;

  typedef union packed {
    cmd_vv_t vv;
    cmd_vi_t vi;
  } cmd_u;

endpackage

// ==== rtl/elem_counter.sv ====
/* Vector length register and element index counter */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module elem_counter import vec_alu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  vl_wr_en,
  input  elem_t                 vl_wdata,
  input  logic                  count_clear,
  input  logic                  count_en,
  output logic [`VEC_IDX_W-1:0] idx,
  output logic                  last,
  output logic [`VEC_VL_W-1:0]  vl
);

  typedef logic [`VEC_VL_W-1:0] vl_t;

  vl_t vl_clamped;

  // Clamp into 1 to VLMAX
  always_comb begin
    if (vl_wdata == '0)
      vl_clamped = vl_t'(1);
    else if (vl_wdata > `VEC_VLMAX)
      vl_clamped = vl_t'(`VEC_VLMAX);
    else
      vl_clamped = vl_wdata[`VEC_VL_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vl  <= vl_t'(`VEC_VLMAX);
      idx <= '0;
    end else begin
      if (vl_wr_en)
        vl <= vl_clamped;
      if (count_clear)
        idx <= '0;
      else if (count_en)
        idx <= idx + 1'b1;
    end
  end

  assign last = ({1'b0, idx} == vl - 1'b1);

endmodule

// ==== rtl/vec_regfile.sv ====
/* Vector register file with a host port and an engine port */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module vec_regfile (
  input  logic                   clk,
  input  logic                   host_we,
  input  logic [`VEC_REG_W-1:0]  host_reg,
  input  logic [`VEC_IDX_W-1:0]  host_idx,
  input  logic [`VEC_ELEM_W-1:0] host_wdata,
  output logic [`VEC_ELEM_W-1:0] host_rdata,
  input  logic [`VEC_REG_W-1:0]  eng_reg_a,
  input  logic [`VEC_REG_W-1:0]  eng_reg_b,
  input  logic [`VEC_IDX_W-1:0]  eng_idx,
  output logic [`VEC_ELEM_W-1:0] eng_rdata_a,
  output logic [`VEC_ELEM_W-1:0] eng_rdata_b,
  input  logic                   eng_we,
  input  logic [`VEC_REG_W-1:0]  eng_wreg,
  input  logic [`VEC_IDX_W-1:0]  eng_widx,
  input  logic [`VEC_ELEM_W-1:0] eng_wdata
);

  logic [`VEC_ELEM_W-1:0] mem [`VEC_NUM_REGS][`VEC_VLMAX];

  // Engine write wins
  always_ff @(posedge clk) begin
    if (eng_we)
      mem[eng_wreg][eng_widx] <= eng_wdata;
    else if (host_we)
      mem[host_reg][host_idx] <= host_wdata;
  end

  // Asynchronous reads
  assign host_rdata  = mem[host_reg][host_idx];
  assign eng_rdata_a = mem[eng_reg_a][eng_idx];
  assign eng_rdata_b = mem[eng_reg_b][eng_idx];

endmodule

// ==== rtl/vec_lane_alu.sv ====
/* Element ALU with operand select and the write-back register stage */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module vec_lane_alu import vec_alu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue,
  input  logic [`VEC_IDX_W-1:0] idx,
  input  alu_fn_t               fn,
  input  logic                  use_imm,
  input  elem_t                 imm,
  input  elem_t                 a,
  input  elem_t                 b,
  output logic                  wr_en,
  output logic [`VEC_IDX_W-1:0] wr_idx,
  output elem_t                 wr_data
);

  localparam int SHAMT_W = $clog2(`VEC_ELEM_W);

  elem_t              op_b;
  elem_t              result;
  logic [SHAMT_W-1:0] shamt;

  // Immediate is broadcast to every element
  assign op_b  = use_imm ? imm : b;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (fn)
      ALU_ADD:  result = a + op_b;
      ALU_SUB:  result = a - op_b;
      ALU_AND:  result = a & op_b;
      ALU_OR:   result = a | op_b;
      ALU_XOR:  result = a ^ op_b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = elem_t'($signed(a) >>> shamt);
      ALU_SLT:  result = elem_t'($signed(a) < $signed(op_b));
      ALU_SLTU: result = elem_t'(a < op_b);
      default:  result = '0;
    endcase
  end

  //------------------------------------------------------------
  // Write-back stage
  //------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      wr_en <= 1'b0;
    else
      wr_en <= issue;
  end

  always_ff @(posedge clk) begin
    wr_idx  <= idx;
    wr_data <= result;
  end

endmodule

// ==== rtl/vec_seq_fsm.sv ====
/* Command sequencer: latches a command and steps the element pipeline
   through IDLE, RUN and DRAIN */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module vec_seq_fsm import vec_alu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  cmd_u                  cmd,
  input  logic                  last,
  output logic                  busy,
  output logic                  count_clear,
  output logic                  count_en,
  output logic [`VEC_REG_W-1:0] rd_reg_a,
  output logic [`VEC_REG_W-1:0] rd_reg_b,
  output logic                  issue,
  output alu_fn_t               fn,
  output logic                  use_imm,
  output elem_t                 imm,
  output logic [`VEC_REG_W-1:0] wr_reg
);

  typedef enum logic [1:0] {IDLE, RUN, DRAIN} state_t;

  state_t state;
  state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      IDLE:
        if (start)
          state_next = RUN;
      RUN:
        if (last)
          state_next = DRAIN;
      // One extra cycle lets the write stage retire the last element
      DRAIN:
        state_next = IDLE;
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      state <= IDLE;
    else
      state <= state_next;
  end

  // Mode picks which view of the command word is decoded
  always_ff @(posedge clk) begin
    if (start) begin
      use_imm  <= cmd.vv.mode;
      fn       <= cmd.vv.fn;
      wr_reg   <= cmd.vv.vd;
      rd_reg_a <= cmd.vv.vs1;
      if (cmd.vi.mode)
        imm <= {{(`VEC_ELEM_W-`VEC_IMM_W){cmd.vi.imm[`VEC_IMM_W-1]}}, cmd.vi.imm};
      else
        rd_reg_b <= cmd.vv.vs2;
    end
  end

  assign busy        = (state != IDLE);
  assign issue       = (state == RUN);
  assign count_en    = issue;
  assign count_clear = start;

endmodule

// ==== rtl/apb_regs.sv ====
/* APB slave for the vector engine: address decode, wait states,
   error response and read data mux */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module apb_regs import vec_alu_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`VEC_APB_ADDR_W-1:0] paddr,
  input  elem_t                      pwdata,
  output elem_t                      prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  logic                       busy,
  output logic                       host_we,
  output logic [`VEC_REG_W-1:0]      host_reg,
  output logic [`VEC_IDX_W-1:0]      host_idx,
  output elem_t                      host_wdata,
  input  elem_t                      host_rdata,
  output logic                       start,
  output cmd_u                       cmd,
  output logic                       vl_wr_en,
  output elem_t                      vl_wdata,
  input  logic [`VEC_VL_W-1:0]       vl
);

  // Byte offset of the word address
  localparam int WORD_LSB = 2;

  logic access;
  logic acc_done;
  logic is_elem;
  logic is_cmd;
  logic is_vl;
  logic is_status;
  logic unmapped;
  logic fn_reserved;
  logic err;
  logic wait_busy;
  logic wr_ok;

  //------------------------------------------------------------
  // Address decode
  //------------------------------------------------------------
  assign is_elem   = ~paddr[`VEC_APB_ADDR_W-1];
  assign is_cmd    = (paddr == `VEC_ADDR_CMD);
  assign is_vl     = (paddr == `VEC_ADDR_VL);
  assign is_status = (paddr == `VEC_ADDR_STATUS);
  assign unmapped  = ~(is_elem | is_cmd | is_vl | is_status);

  // Register number above the element index
  assign host_idx = paddr[WORD_LSB +: `VEC_IDX_W];
  assign host_reg = paddr[WORD_LSB + `VEC_IDX_W +: `VEC_REG_W];

  assign host_wdata = pwdata;
  assign vl_wdata   = pwdata;
  assign cmd        = pwdata;

  assign fn_reserved = (cmd.vv.fn > ALU_SLTU);

  assign err = unmapped
             | (is_status & pwrite)
             | (is_cmd & ~pwrite)
             | (is_cmd & pwrite & fn_reserved);

  //------------------------------------------------------------
  // Handshake
  //------------------------------------------------------------
  assign access = psel & penable;

  // Element, VL write and CMD write all wait for the engine
  assign wait_busy = busy & ~err & (is_elem | (pwrite & (is_cmd | is_vl)));

  assign pready  = access & ~acc_done & ~wait_busy;
  assign pslverr = pready & err;
  assign wr_ok   = pready & pwrite & ~err;

  assign host_we  = wr_ok & is_elem;
  assign start    = wr_ok & is_cmd;
  assign vl_wr_en = wr_ok & is_vl;

  // A finished transfer is acknowledged only once
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_done <= 1'b0;
    end else if (~penable) begin
      acc_done <= 1'b0;
    end else if (pready) begin
      acc_done <= 1'b1;
    end
  end

  always_comb begin
    prdata = '0;
    if (is_elem)
      prdata = host_rdata;
    else if (is_vl)
      prdata = elem_t'(vl);
    else if (is_status)
      prdata = elem_t'(busy);
  end

endmodule

// ==== rtl/vec_alu_top.sv ====
/* Vector ALU engine top: APB registers, sequencer, element counter,
   vector register file and lane ALU */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module vec_alu_top import vec_alu_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`VEC_APB_ADDR_W-1:0] paddr,
  input  elem_t                      pwdata,
  output elem_t                      prdata,
  output logic                       pready,
  output logic                       pslverr
);

  // Host port of the register file
  logic                  host_we;
  logic [`VEC_REG_W-1:0] host_reg;
  logic [`VEC_IDX_W-1:0] host_idx;
  elem_t                 host_wdata;
  elem_t                 host_rdata;

  // Command and length handoff
  logic                 start;
  cmd_u                 cmd;
  logic                 busy;
  logic                 vl_wr_en;
  elem_t                vl_wdata;
  logic [`VEC_VL_W-1:0] vl;

  // Element sequencing
  logic                  count_clear;
  logic                  count_en;
  logic [`VEC_IDX_W-1:0] idx;
  logic                  last;

  // Engine datapath
  logic [`VEC_REG_W-1:0] rd_reg_a;
  logic [`VEC_REG_W-1:0] rd_reg_b;
  logic [`VEC_REG_W-1:0] wr_reg;
  logic                  issue;
  alu_fn_t               fn;
  logic                  use_imm;
  elem_t                 imm;
  elem_t                 rdata_a;
  elem_t                 rdata_b;
  logic                  wb_en;
  logic [`VEC_IDX_W-1:0] wb_idx;
  elem_t                 wb_data;

  apb_regs i_apb_regs (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .busy(busy),
    .host_we(host_we), .host_reg(host_reg), .host_idx(host_idx),
    .host_wdata(host_wdata), .host_rdata(host_rdata),
    .start(start), .cmd(cmd),
    .vl_wr_en(vl_wr_en), .vl_wdata(vl_wdata), .vl(vl)
  );

  vec_seq_fsm i_vec_seq_fsm (
    .clk(clk), .reset(reset),
    .start(start), .cmd(cmd), .last(last), .busy(busy),
    .count_clear(count_clear), .count_en(count_en),
    .rd_reg_a(rd_reg_a), .rd_reg_b(rd_reg_b),
    .issue(issue), .fn(fn), .use_imm(use_imm), .imm(imm), .wr_reg(wr_reg)
  );

  elem_counter i_elem_counter (
    .clk(clk), .reset(reset),
    .vl_wr_en(vl_wr_en), .vl_wdata(vl_wdata),
    .count_clear(count_clear), .count_en(count_en),
    .idx(idx), .last(last), .vl(vl)
  );

  vec_regfile i_vec_regfile (
    .clk(clk),
    .host_we(host_we), .host_reg(host_reg), .host_idx(host_idx),
    .host_wdata(host_wdata), .host_rdata(host_rdata),
    .eng_reg_a(rd_reg_a), .eng_reg_b(rd_reg_b), .eng_idx(idx),
    .eng_rdata_a(rdata_a), .eng_rdata_b(rdata_b),
    .eng_we(wb_en), .eng_wreg(wr_reg), .eng_widx(wb_idx), .eng_wdata(wb_data)
  );

  vec_lane_alu i_vec_lane_alu (
    .clk(clk), .reset(reset),
    .issue(issue), .idx(idx), .fn(fn), .use_imm(use_imm),
    .imm(imm), .a(rdata_a), .b(rdata_b),
    .wr_en(wb_en), .wr_idx(wb_idx), .wr_data(wb_data)
  );

endmodule

// ==== sim/vec_alu_asserts.sv ====
/* Concurrent assertions on the APB handshake and command sequencing */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module vec_alu_asserts (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic busy,
  input logic start
);

  // Busy cycles seen before the current one
  int unsigned busy_run;

  always_ff @(posedge clk) begin
    if (reset || !busy)
      busy_run <= 0;
    else
      busy_run <= busy_run + 1;
  end

  assert property (@(posedge clk) disable iff (reset) pready |-> (psel && penable))
    else $error("pready high outside an APB access phase");

  assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
    else $error("pslverr high without pready");

  // vl issue cycles plus one drain cycle at most
  assert property (@(posedge clk) disable iff (reset) busy |-> (busy_run <= `VEC_VLMAX))
    else $error("busy held longer than VLMAX+1 cycles");

  assert property (@(posedge clk) disable iff (reset) start |-> !busy)
    else $error("start pulse while the engine is busy");

endmodule

bind vec_alu_top vec_alu_asserts i_vec_alu_asserts (
  .clk(clk),
  .reset(reset),
  .psel(psel),
  .penable(penable),
  .pready(pready),
  .pslverr(pslverr),
  .busy(busy),
  .start(start)
);

// ==== sim/tb_vec_alu.sv ====
/* Directed testbench for the vector ALU engine: register file model,
   APB tasks, value checker and watchdog */
`timescale 1ns/100ps
`include "vec_alu_cfg.svh"

module tb_vec_alu import vec_alu_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
  // Roughly 1500 cycles of APB traffic, so 30 us plus a wide margin
  localparam int WATCHDOG_NS  = 200_000;

  logic                       clk;
  logic                       reset;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`VEC_APB_ADDR_W-1:0] paddr;
  elem_t                      pwdata;
  elem_t                      prdata;
  logic                       pready;
  logic                       pslverr;

  // Expected register file contents and vector length
  elem_t model [`VEC_NUM_REGS][`VEC_VLMAX];
  int    model_vl;
  int    seed;
  int    last_waits;

  vec_alu_top i_vec_alu_top (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #WATCHDOG_NS;
    $display("Watchdog expired: an APB transfer or a vector command never finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped by the watchdog");
  end

  //------------------------------------------------------------
  // Checker, model and APB tasks
  //------------------------------------------------------------
  task automatic check(input elem_t actual, input elem_t expected, input string msg);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  function automatic elem_t alu_model(input int fn, input elem_t a, input elem_t b);
    case (fn)
      0:       return a + b;
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return a << b[4:0];
      6:       return a >> b[4:0];
      7:       return $signed(a) >>> b[4:0];
      8:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      9:       return (a < b) ? 32'd1 : 32'd0;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [`VEC_APB_ADDR_W-1:0] elem_addr(input int r, input int i);
    logic [`VEC_REG_W-1:0] reg_num;
    logic [`VEC_IDX_W-1:0] idx;
    reg_num = 2'(r);
    idx     = 3'(i);
    return {1'b0, reg_num, idx, 2'b00};
  endfunction

  // Starts on a falling edge and returns on the falling edge after completion
  task automatic apb_transfer(input logic write, input logic [`VEC_APB_ADDR_W-1:0] addr,
                              input elem_t wdata, output elem_t rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable    = 1'b1;
    last_waits = 0;
    #SAMPLE_DELAY;
    while (!pready) begin
      last_waits++;
      @(negedge clk);
      #SAMPLE_DELAY;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [`VEC_APB_ADDR_W-1:0] addr, input elem_t data,
                           output logic err);
    elem_t unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`VEC_APB_ADDR_W-1:0] addr, output elem_t data,
                          output logic err);
    apb_transfer(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic fill_random();
    logic err;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      for (int i = 0; i < `VEC_VLMAX; i++) begin
        model[r][i] = $random(seed);
        apb_write(elem_addr(r, i), model[r][i], err);
        check(elem_t'(err), 32'd0, "element write flagged an error");
      end
    end
  endtask

  task automatic verify_reg(input int r);
    elem_t data;
    logic  err;
    for (int i = 0; i < `VEC_VLMAX; i++) begin
      apb_read(elem_addr(r, i), data, err);
      check(elem_t'(err), 32'd0, "element read flagged an error");
      check(data, model[r][i], $sformatf("element v%0d[%0d]", r, i));
    end
  endtask

  task automatic verify_all();
    elem_t data;
    logic  err;
    for (int r = 0; r < `VEC_NUM_REGS; r++)
      verify_reg(r);
    apb_read(`VEC_ADDR_VL, data, err);
    check(data, 32'(model_vl), "VL readback");
  endtask

  task automatic set_vl(input elem_t value, input int expected);
    elem_t data;
    logic  err;
    apb_write(`VEC_ADDR_VL, value, err);
    check(elem_t'(err), 32'd0, "VL write flagged an error");
    model_vl = expected;
    apb_read(`VEC_ADDR_VL, data, err);
    check(data, 32'(expected), "clamped VL readback");
  endtask

  task automatic issue_cmd(input logic mode, input int fn, input int vd, input int vs1,
                           input int vs2, input logic [`VEC_IMM_W-1:0] imm);
    elem_t       results [`VEC_VLMAX];
    elem_t       opb;
    logic [31:0] word;
    logic        err;
    if (mode)
      word = {1'b1, 4'(fn), 2'(vd), 2'(vs1), 11'd0, imm};
    else
      word = {1'b0, 4'(fn), 2'(vd), 2'(vs1), 21'd0, 2'(vs2)};
    // Every element sees the old contents, even when vd is a source
    for (int i = 0; i < model_vl; i++) begin
      opb = mode ? {{(`VEC_ELEM_W-`VEC_IMM_W){imm[`VEC_IMM_W-1]}}, imm} : model[vs2][i];
      results[i] = alu_model(fn, model[vs1][i], opb);
    end
    for (int i = 0; i < model_vl; i++)
      model[vd][i] = results[i];
    apb_write(`VEC_ADDR_CMD, word, err);
    check(elem_t'(err), 32'd0, "valid command rejected");
  endtask

  task automatic wait_idle();
    elem_t status;
    logic  err;
    status = 32'd1;
    while (status[0])
      apb_read(`VEC_ADDR_STATUS, status, err);
  endtask

  task automatic run_cmd(input logic mode, input int fn, input int vd, input int vs1,
                         input int vs2, input logic [`VEC_IMM_W-1:0] imm);
    issue_cmd(mode, fn, vd, vs1, vs2, imm);
    wait_idle();
    verify_reg(vd);
  endtask

  //------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------
  task automatic test_reset_state();
    elem_t data;
    logic  err;
    apb_read(`VEC_ADDR_STATUS, data, err);
    check(data, 32'd0, "STATUS after reset");
    apb_read(`VEC_ADDR_VL, data, err);
    check(data, 32'(`VEC_VLMAX), "VL after reset");
    model_vl = `VEC_VLMAX;
    fill_random();
    for (int r = 0; r < `VEC_NUM_REGS; r++)
      verify_reg(r);
  endtask

  task automatic test_vl_clamp();
    set_vl(32'd0, 1);
    set_vl(32'd5, 5);
    set_vl(32'd20, 8);
  endtask

  task automatic test_vv_ops();
    set_vl(32'd8, 8);
    for (int f = 0; f < 10; f++) begin
      fill_random();
      // Every third command overwrites its first source
      run_cmd(1'b0, f, f % 4, (f % 3 == 0) ? f % 4 : (f + 1) % 4, (f + 2) % 4, 12'd0);
    end
  endtask

  task automatic test_vi_ops();
    int                    fns [6];
    logic [`VEC_IMM_W-1:0] imms [6];
    fns  = '{0, 1, 4, 7, 8, 9};
    imms = '{12'hffb, 12'd100, 12'h800, 12'd2047, 12'hfff, 12'd3};
    set_vl(32'd3, 3);
    fill_random();
    for (int k = 0; k < 6; k++)
      run_cmd(1'b1, fns[k], k % 4, (k == 2) ? k % 4 : (k + 1) % 4, 0, imms[k]);
  endtask

  task automatic test_back_pressure();
    elem_t data;
    logic  err;
    set_vl(32'd8, 8);
    fill_random();
    issue_cmd(1'b0, 0, 3, 0, 1, 12'd0);
    apb_read(`VEC_ADDR_STATUS, data, err);
    check(data, 32'd1, "STATUS right after a command");
    apb_read(elem_addr(3, 7), data, err);
    check(elem_t'(last_waits > 0), 32'd1, "element read not held while busy");
    check(data, model[3][7], "element read behind a running command");
    apb_read(`VEC_ADDR_STATUS, data, err);
    check(data, 32'd0, "STATUS after the run");
    verify_reg(3);
  endtask

  task automatic test_errors();
    elem_t data;
    logic  err;
    apb_write(8'h8c, $random(seed), err);
    check(elem_t'(err), 32'd1, "write to an unmapped address");
    apb_read(8'hfc, data, err);
    check(elem_t'(err), 32'd1, "read of an unmapped address");
    apb_write(`VEC_ADDR_STATUS, 32'd1, err);
    check(elem_t'(err), 32'd1, "write to STATUS");
    apb_read(`VEC_ADDR_CMD, data, err);
    check(elem_t'(err), 32'd1, "read of CMD");
    apb_write(`VEC_ADDR_CMD, {1'b0, 4'd12, 2'd0, 2'd1, 21'd0, 2'd2}, err);
    check(elem_t'(err), 32'd1, "command with a reserved fn");
    apb_read(`VEC_ADDR_STATUS, data, err);
    check(data, 32'd0, "engine started by a rejected command");
    verify_all();
  endtask

  initial begin
    seed    = 32'h9daa;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_vl_clamp();
    test_vv_ops();
    test_vi_ops();
    test_back_pressure();
    test_errors();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== vec_alu_top.f ====
+incdir+rtl
rtl/vec_alu_pkg.sv
rtl/elem_counter.sv
rtl/vec_regfile.sv
rtl/vec_lane_alu.sv
rtl/vec_seq_fsm.sv
rtl/apb_regs.sv
rtl/vec_alu_top.sv
sim/vec_alu_asserts.sv
sim/tb_vec_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the vector ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f vec_alu_top.f \
  --top-module tb_vec_alu \
  -Mdir obj_dir -o sim_vec_alu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_vec_alu
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
